//--- Bender.yml
package:
  name: instr_cache

sources:
  - cache_types.sv
  - instr_serve.sv
  - cache_way_array.sv
  - plru.sv
  - instr_cachefsm.sv
  - instr_cache.sv
  - target: test
    files:
      - instr_cache_assert.sv
      - tb_instr_cache.sv

//--- cache_types.sv
package cache_types;

  // Cache geometry
  localparam int NUM_WAYS       = 4;
  localparam int NUM_SETS       = 16;
  localparam int TAG_BITS       = 23;
  localparam int SET_BITS       = 4;
  localparam int LINE_BITS      = 256;
  localparam int BEAT_BITS      = 64;
  localparam int BEATS_PER_LINE = 4;
  localparam int WORD_SEL_BITS  = 3;

  typedef struct packed {
    logic [TAG_BITS-1:0]      tag;
    logic [SET_BITS-1:0]      set;
    logic [WORD_SEL_BITS-1:0] word;
    logic [1:0]               byte_ofs;
  } addr_fields_t;

  // Raw view goes to memory, field view drives indexing
  typedef union packed {
    logic [31:0]  raw;
    addr_fields_t fields;
  } fetch_addr_u;

  typedef struct packed {
    fetch_addr_u addr;
    logic [3:0]  rmask;
  } fetch_req_t;

  typedef enum logic [1:0] {Sram_idle, Hit_read, Miss_replace} sram_op_t;

  typedef enum logic {Hit, Clean_miss} hit_miss_t;

  typedef enum logic [1:0] {Way_A, Way_B, Way_C, Way_D} way_t;

  typedef struct packed {
    sram_op_t   sram_op;
    logic [1:0] bank_shift;
  } cache_ctl_t;

  typedef struct packed {
    logic [BEAT_BITS-1:0] rdata;
    logic [31:0]          raddr;
    logic                 rvalid;
  } mem_beat_t;

endpackage

//--- cache_way_array.sv
`timescale 1ns/1ps

module cache_way_array (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               rd_en,
  input  logic                               wr_en,
  input  logic [cache_types::SET_BITS-1:0]   set,
  input  logic [1:0]                         beat_sel,
  input  logic [cache_types::BEAT_BITS-1:0]  wr_beat,
  input  logic [cache_types::TAG_BITS-1:0]   wr_tag,
  output logic [cache_types::LINE_BITS-1:0]  rd_line,
  output logic [cache_types::TAG_BITS-1:0]   rd_tag,
  output logic                               rd_valid
);
  import cache_types::*;

  logic [LINE_BITS-1:0] data_mem [NUM_SETS];
  logic [TAG_BITS-1:0]  tag_mem  [NUM_SETS];
  logic [NUM_SETS-1:0]  valid_q;
  logic                 last_beat;

  assign last_beat = (beat_sel == 2'(BEATS_PER_LINE - 1));

  // Line and tag storage, one beat written per refill strobe
  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[set][BEAT_BITS*beat_sel +: BEAT_BITS] <= wr_beat;
      tag_mem[set] <= wr_tag;
    end
    if (rd_en) begin
      rd_line <= data_mem[set];
      rd_tag  <= tag_mem[set];
    end
  end

  // Valid drops on early beats and rises with the last one
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q  <= '0;
      rd_valid <= 1'b0;
    end else begin
      if (wr_en) begin
        valid_q[set] <= last_beat;
      end
      if (rd_en) begin
        rd_valid <= valid_q[set];
      end
    end
  end

endmodule

//--- icache_trace.txt
# test  address  hit  expected word (test in decimal, address and word in hex)
# hit column: 0 miss, 1 hit, 2 reset before the fetch and then a miss
1 00001000 0 5a5ad3c3
2 0000101c 1 5a5ad3df
2 00001004 1 5a5ad3c7
2 00001008 1 5a5ad3cb
2 00001000 1 5a5ad3c3
2 00001014 1 5a5ad3d7
2 0000100c 1 5a5ad3cf
2 00001018 1 5a5ad3db
2 00001010 1 5a5ad3d3
3 00002060 0 5a5ae3a3
3 00004064 0 5a5a83a7
3 00006068 0 5a5aa3ab
3 0000807c 0 5a5a43bf
3 00006060 1 5a5aa3a3
3 00002064 1 5a5ae3a7
3 00008070 1 5a5a43b3
3 00004068 1 5a5a83ab
4 0000a060 0 5a5a63a3
4 0000606c 0 5a5aa3af
4 00004060 1 5a5a83a3
4 00008060 1 5a5a43a3
4 0000a064 1 5a5a63a7
4 00002060 0 5a5ae3a3
5 00012344 0 5a5be087
5 00012358 1 5a5be09b
5 0abcdef0 0 50e61d33
5 0abcdee4 1 50e61d27
5 fffffffc 0 a5a53c3f
5 ffffffe0 1 a5a53c23
5 00000000 0 5a5ac3c3
5 00000010 1 5a5ac3d3
6 00001000 2 5a5ad3c3
6 00001004 1 5a5ad3c7
6 00004064 0 5a5a83a7
6 00012344 0 5a5be087
6 0abcdef0 0 50e61d33

//--- instr_cache.sv
`timescale 1ns/1ps

module instr_cache (
  input  logic                    clk,
  input  logic                    rst,

  // CPU fetch port
  input  cache_types::fetch_req_t cpu_req,
  output logic [31:0]             ufp_rdata,
  output logic                    ufp_resp,

  // Memory line port
  input  logic                    bfp_ready,
  input  cache_types::mem_beat_t  mem_beat,
  output logic [31:0]             bfp_addr,
  output logic                    bfp_read
);
  import cache_types::*;

  fetch_req_t           req_q;
  cache_ctl_t           ctl;
  hit_miss_t            hit_miss;
  way_t                 visit_way;
  way_t                 replace_way;
  mem_beat_t            fsm_beat;
  logic                 rd_en;
  logic [SET_BITS-1:0]  cur_set;
  logic [TAG_BITS-1:0]  cur_tag;
  logic [31:0]          line_addr;
  logic [LINE_BITS-1:0] rd_line [NUM_WAYS];
  logic [TAG_BITS-1:0]  rd_tag  [NUM_WAYS];
  logic [NUM_WAYS-1:0]  rd_valid;
  logic [NUM_WAYS-1:0]  way_hit;
  logic [NUM_WAYS-1:0]  wr_en;

  assign cur_set   = req_q.addr.fields.set;
  assign cur_tag   = req_q.addr.fields.tag;
  assign rd_en     = (req_q.rmask != '0);
  assign line_addr = {req_q.addr.raw[31:5], 5'b0};
  assign bfp_addr  = bfp_read ? line_addr : '0;

  // Only beats for the line being refilled count
  always_comb begin
    fsm_beat        = mem_beat;
    fsm_beat.rvalid = mem_beat.rvalid && (mem_beat.raddr[31:5] == line_addr[31:5]);
  end

  // Tag compare and hit way
  always_comb begin
    visit_way = Way_A;
    for (int i = 0; i < NUM_WAYS; i++) begin
      way_hit[i] = rd_valid[i] && (rd_tag[i] == cur_tag);
    end
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (way_hit[i]) begin
        visit_way = way_t'(i);
      end
    end
    hit_miss = (way_hit != '0) ? Hit : Clean_miss;
  end

  always_comb begin
    ufp_rdata = '0;
    if (ctl.sram_op == Hit_read) begin
      ufp_rdata = rd_line[visit_way][32*req_q.addr.fields.word +: 32];
    end
  end

  // Refill beats go to the victim way only
  always_comb begin
    for (int i = 0; i < NUM_WAYS; i++) begin
      wr_en[i] = (ctl.sram_op == Miss_replace) && (replace_way == way_t'(i));
    end
  end

  instr_serve instr_serve (
    .clk     (clk),
    .rst     (rst),
    .cpu_req (cpu_req),
    .ufp_resp(ufp_resp),
    .req_q   (req_q)
  );

  instr_cachefsm instr_cachefsm (
    .clk      (clk),
    .rst      (rst),
    .req_valid(rd_en),
    .hit_miss (hit_miss),
    .bfp_ready(bfp_ready),
    .mem_beat (fsm_beat),
    .ctl      (ctl),
    .ufp_resp (ufp_resp),
    .bfp_read (bfp_read)
  );

  plru plru (
    .clk        (clk),
    .rst        (rst),
    .ufp_resp   (ufp_resp),
    .set        (cur_set),
    .valid      (rd_valid),
    .visit_way  (visit_way),
    .replace_way(replace_way)
  );

  generate
    for (genvar i = 0; i < NUM_WAYS; i++) begin : arrays
      cache_way_array way_array (
        .clk     (clk),
        .rst     (rst),
        .rd_en   (rd_en),
        .wr_en   (wr_en[i]),
        .set     (cur_set),
        .beat_sel(ctl.bank_shift),
        .wr_beat (mem_beat.rdata),
        .wr_tag  (cur_tag),
        .rd_line (rd_line[i]),
        .rd_tag  (rd_tag[i]),
        .rd_valid(rd_valid[i])
      );
    end
  endgenerate

endmodule

//--- instr_cache_assert.sv
`timescale 1ns/1ps

module instr_cache_assert (
  input logic                   clk,
  input logic                   rst,
  input logic                   ufp_resp,
  input logic                   bfp_read,
  input logic [31:0]            bfp_addr,
  input cache_types::mem_beat_t beat
);

  logic [2:0] beats_seen;

  // Beats of the line read now in flight
  always_ff @(posedge clk) begin
    if (rst || !bfp_read) begin
      beats_seen <= '0;
    end else if (beat.rvalid) begin
      beats_seen <= beats_seen + 3'd1;
    end
  end

  resp_pulse: assert property (@(posedge clk) disable iff (rst) ufp_resp |=> !ufp_resp)
    else $error("ufp_resp stayed high for more than one cycle");

  read_held: assert property (@(posedge clk) disable iff (rst)
    bfp_read && !(beat.rvalid && beats_seen == 3'd3) |=> bfp_read)
    else $error("bfp_read dropped before the fourth beat");

  // Line address is aligned and does not move while the read is out
  addr_aligned: assert property (@(posedge clk) disable iff (rst)
    bfp_read |-> bfp_addr[4:0] == 5'b0 && (!$past(bfp_read) || $stable(bfp_addr)))
    else $error("bfp_addr not line aligned or changed during a read");

  quiet_after_reset: assert property (@(posedge clk) rst |=> !ufp_resp && !bfp_read)
    else $error("ufp_resp or bfp_read high right after reset");

endmodule

bind instr_cache instr_cache_assert protocol_checks (
  .clk     (clk),
  .rst     (rst),
  .ufp_resp(ufp_resp),
  .bfp_read(bfp_read),
  .bfp_addr(bfp_addr),
  .beat    (fsm_beat)
);

//--- instr_cachefsm.sv
`timescale 1ns/1ps

module instr_cachefsm (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   req_valid,
  input  cache_types::hit_miss_t hit_miss,
  input  logic                   bfp_ready,
  input  cache_types::mem_beat_t mem_beat,
  output cache_types::cache_ctl_t ctl,
  output logic                   ufp_resp,
  output logic                   bfp_read
);
  import cache_types::*;

  typedef enum logic [2:0] {
    Idle,
    Lookup,
    Miss_req,
    Miss_fill,
    Reread
  } state_t;

  state_t     state_q;
  state_t     state_d;
  logic [1:0] beat_q;
  logic       last_beat;

  assign last_beat = (beat_q == 2'(BEATS_PER_LINE - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= Idle;
      beat_q  <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == Miss_req) begin
        beat_q <= '0;
      end else if (state_q == Miss_fill && mem_beat.rvalid) begin
        beat_q <= beat_q + 2'd1;
      end
    end
  end

  always_comb begin
    state_d        = state_q;
    ctl.sram_op    = Sram_idle;
    ctl.bank_shift = beat_q;
    ufp_resp       = 1'b0;
    bfp_read       = 1'b0;
    unique case (state_q)
      Idle: begin
        if (req_valid) begin
          state_d = Lookup;
        end
      end
      Lookup: begin
        if (!req_valid) begin
          state_d = Idle;
        end else if (hit_miss == Hit) begin
          ctl.sram_op = Hit_read;
          ufp_resp    = 1'b1;
          state_d     = Idle;
        end else begin
          state_d = Miss_req;
        end
      end
      Miss_req: begin
        // Read only goes out while memory is ready
        if (bfp_ready) begin
          bfp_read = 1'b1;
          state_d  = Miss_fill;
        end
      end
      Miss_fill: begin
        bfp_read = 1'b1;
        if (mem_beat.rvalid) begin
          ctl.sram_op = Miss_replace;
          if (last_beat) begin
            state_d = Reread;
          end
        end
      end
      Reread: begin
        // Array output is refreshed one cycle after the last write
        state_d = Lookup;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

endmodule

//--- instr_serve.sv
`timescale 1ns/1ps

module instr_serve (
  input  logic                   clk,
  input  logic                   rst,
  input  cache_types::fetch_req_t cpu_req,
  input  logic                   ufp_resp,
  output cache_types::fetch_req_t req_q
);

  logic empty;

  assign empty = (req_q.rmask == '0);

  // The CPU still holds the answered request during ufp_resp, so
  // the register retires it there and takes the next one a cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      req_q <= '0;
    end else if (ufp_resp) begin
      req_q <= '0;
    end else if (empty) begin
      req_q <= cpu_req;
    end
  end

endmodule

//--- plru.sv
`timescale 1ns/1ps

module plru (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             ufp_resp,
  input  logic [cache_types::SET_BITS-1:0] set,
  input  logic [cache_types::NUM_WAYS-1:0] valid,
  input  cache_types::way_t                visit_way,
  output cache_types::way_t                replace_way
);
  import cache_types::*;

  // Per set: [2] root picks A/B or C/D, [1] A/B leaf, [0] C/D leaf
  logic [NUM_SETS-1:0][2:0] tree_q;
  logic [2:0]               cur_bits;

  assign cur_bits = tree_q[set];

  always_ff @(posedge clk) begin
    if (rst) begin
      tree_q <= '0;
    end else if (ufp_resp) begin
      if (visit_way == Way_A || visit_way == Way_B) begin
        tree_q[set][2] <= 1'b1;
        tree_q[set][1] <= (visit_way == Way_A);
      end else begin
        tree_q[set][2] <= 1'b0;
        tree_q[set][0] <= (visit_way == Way_C);
      end
    end
  end

  always_comb begin
    if (!cur_bits[2]) begin
      replace_way = cur_bits[1] ? Way_B : Way_A;
    end else begin
      replace_way = cur_bits[0] ? Way_D : Way_C;
    end
    // Lowest invalid way wins over the tree
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (!valid[i]) begin
        replace_way = way_t'(i);
      end
    end
  end

endmodule

//--- tb.f
cache_types.sv
instr_serve.sv
cache_way_array.sv
plru.sv
instr_cachefsm.sv
instr_cache.sv
instr_cache_assert.sv
tb_instr_cache.sv

//--- tb_instr_cache.sv
`timescale 1ns/1ps

module tb_instr_cache;
  import cache_types::*;

  localparam int          PERIOD           = 40;
  localparam int          CYCLES_PER_FETCH = 4 * 8 + 12;
  localparam logic [31:0] MEM_KEY          = 32'h5a5a_c3c3;

  logic        clk;
  logic        rst;
  fetch_req_t  cpu_req;
  logic [31:0] ufp_rdata;
  logic        ufp_resp;
  logic        bfp_ready;
  mem_beat_t   mem_beat;
  logic [31:0] bfp_addr;
  logic        bfp_read;

  int          t_num[$];
  logic [31:0] t_addr[$];
  int          t_flag[$];
  logic [31:0] t_word[$];

  // Reference tags, valid bits and tree bits per set
  logic [22:0] ref_tag [16][4];
  logic [3:0]  ref_valid [16];
  logic        ref_root [16];
  logic        ref_ab [16];
  logic        ref_cd [16];

  int errors;
  int test_errors;
  int tests_done;

  instr_cache instr_cache_inst (.*);

  always #(PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    if (rst) begin
      bfp_ready <= 1'b0;
    end else begin
      bfp_ready <= ($urandom_range(0, 3) != 0);
    end
  end

  // Memory returns a line in four beats with random gaps
  always begin : mem_model
    logic [31:0] line_base;
    int          gap;
    @(negedge clk);
    if (bfp_read) begin
      line_base = bfp_addr;
      for (int b = 0; b < 4; b++) begin
        gap = $urandom_range(0, 7);
        repeat (gap) begin
          @(posedge clk);
          mem_beat.rvalid <= 1'b0;
        end
        @(posedge clk);
        mem_beat.rdata  <= {(line_base + 8 * b + 4) ^ MEM_KEY, (line_base + 8 * b) ^ MEM_KEY};
        mem_beat.raddr  <= line_base;
        mem_beat.rvalid <= 1'b1;
      end
      @(posedge clk);
      mem_beat.rvalid <= 1'b0;
    end
  end

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic apply_reset();
    cpu_req <= '0;
    rst     <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    for (int s = 0; s < 16; s++) begin
      ref_valid[s] = '0;
      ref_root[s]  = 1'b0;
      ref_ab[s]    = 1'b0;
      ref_cd[s]    = 1'b0;
    end
  endtask

  task automatic ref_access(input logic [31:0] addr, output logic hit);
    int          s;
    int          w;
    logic [22:0] tag;
    s   = addr[8:5];
    tag = addr[31:9];
    hit = 1'b0;
    w   = 0;
    for (int i = 0; i < 4; i++) begin
      if (!hit && ref_valid[s][i] && ref_tag[s][i] == tag) begin
        hit = 1'b1;
        w   = i;
      end
    end
    if (!hit) begin
      if (ref_valid[s] != 4'hf) begin
        while (ref_valid[s][w]) begin
          w++;
        end
      end else if (ref_root[s]) begin
        w = ref_cd[s] ? 3 : 2;
      end else begin
        w = ref_ab[s] ? 1 : 0;
      end
      ref_valid[s][w] = 1'b1;
      ref_tag[s][w]   = tag;
    end
    // Path bits point away from the way just used
    ref_root[s] = (w < 2);
    if (w < 2) begin
      ref_ab[s] = (w == 0);
    end else begin
      ref_cd[s] = (w == 2);
    end
  endtask

  task automatic run_fetch(input int idx);
    logic [31:0] addr;
    logic        exp_hit;
    logic        ref_hit;
    logic        prev_read;
    int          cycles;
    int          reads;
    addr      = t_addr[idx];
    exp_hit   = (t_flag[idx] == 1);
    prev_read = 1'b0;
    cycles    = 0;
    reads     = 0;
    ref_access(addr, ref_hit);
    @(posedge clk);
    cpu_req.addr.raw <= addr;
    cpu_req.rmask    <= 4'hf;
    do begin
      @(negedge clk);
      cycles++;
      if (bfp_read && !prev_read) begin
        reads++;
      end
      if (bfp_read) begin
        assert (bfp_addr == {addr[31:5], 5'b0}) else begin
          $display("Fail at %0t: bfp_addr %h for fetch %h", $time, bfp_addr, addr);
          count_error();
        end
      end
      prev_read = bfp_read;
    end while (!ufp_resp);
    assert (ufp_rdata == t_word[idx]) else begin
      $display("Fail at %0t: fetch %h returned %h, expected %h",
               $time, addr, ufp_rdata, t_word[idx]);
      count_error();
    end
    assert (reads == (ref_hit ? 0 : 1)) else begin
      $display("Fail at %0t: fetch %h made %0d line reads, expected hit %0b",
               $time, addr, reads, ref_hit);
      count_error();
    end
    assert (ref_hit == exp_hit) else begin
      $display("Fail at %0t: PLRU model predicts hit %0b for fetch %h", $time, ref_hit, addr);
      count_error();
    end
    // Capture is one edge after the drive
    if (exp_hit) begin
      assert (cycles - 1 == 2) else begin
        $display("Fail at %0t: hit on %h answered %0d cycles after capture",
                 $time, addr, cycles - 1);
        count_error();
      end
    end
  endtask

  task automatic report_test(input int num, input int fetches);
    $display("Test %0d: %0d fetches, %0d errors", num, fetches, test_errors);
    test_errors = 0;
    tests_done++;
  endtask

  initial begin
    int          fd;
    string       text;
    int          num;
    int          flag;
    logic [31:0] addr;
    logic [31:0] word;
    int          cur_test;
    int          fetches;
    clk         = 1'b0;
    rst         = 1'b1;
    cpu_req     = '0;
    bfp_ready   = 1'b0;
    mem_beat    = '0;
    errors      = 0;
    test_errors = 0;
    tests_done  = 0;
    void'($urandom(32'ha0973d6e));
    fd = $fopen("icache_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file icache_trace.txt");
      $display("RESULT: FAIL");
      $finish;
    end
    while ($fgets(text, fd) != 0) begin
      if ($sscanf(text, "%d %h %d %h", num, addr, flag, word) == 4) begin
        t_num.push_back(num);
        t_addr.push_back(addr);
        t_flag.push_back(flag);
        t_word.push_back(word);
      end
    end
    $fclose(fd);
    fork
      begin
        #(t_addr.size() * CYCLES_PER_FETCH * PERIOD + 20 * PERIOD);
        $display("Timeout: the fetches did not all finish in time");
        $display("RESULT: FAIL");
        $finish;
      end
    join_none
    apply_reset();
    cur_test = t_num[0];
    fetches  = 0;
    foreach (t_addr[i]) begin
      if (t_num[i] != cur_test) begin
        report_test(cur_test, fetches);
        cur_test = t_num[i];
        fetches  = 0;
      end
      // Flag 2 pulses reset before the fetch
      if (t_flag[i] == 2) begin
        @(posedge clk);
        apply_reset();
      end
      run_fetch(i);
      fetches++;
    end
    report_test(cur_test, fetches);
    $display("Tests: %0d, fetches: %0d, errors: %0d", tests_done, t_addr.size(), errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
